// File: source/cpu_defs.svh
/*
 * Core sizing macros for the 16-bit register-to-register processor
 */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Data path word width
`define CPU_WIDTH 16

// Register file depth
`define CPU_REGS 8

// Bits needed to name one register
`define CPU_SEL_W 3

// Shift and rotate amount taken from the second operand
`define CPU_SHAMT_W 4

`endif

// File: source/cpu_pkg.sv
/*
 * Shared types for the processor core: data word, register select,
 * the decoded views of one instruction word, ALU operations and opcodes
 */
`include "cpu_defs.svh"

package cpu_pkg;

	typedef logic [`CPU_WIDTH-1:0] word_t;
	typedef logic [`CPU_SEL_W-1:0] reg_sel_t;

	// Register format, rd written from rs and rt
	typedef struct packed {
		logic [4:0] opcode;
		reg_sel_t   rs;
		reg_sel_t   rt;
		reg_sel_t   rd;
		logic [1:0] funct;
	} r_fmt_t;

	// Immediate format with 5-bit immediate
	typedef struct packed {
		logic [4:0] opcode;
		reg_sel_t   rs;
		reg_sel_t   rd;
		logic [4:0] imm5;
	} i_fmt_t;

	// Long immediate, rs is also the destination
	typedef struct packed {
		logic [4:0] opcode;
		reg_sel_t   rs;
		logic [7:0] imm8;
	} l_fmt_t;

	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		l_fmt_t l;
	} instr_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_ANDN,
		ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL,
		ALU_PASS_B, ALU_SLBI, ALU_BTR,
		ALU_SEQ, ALU_SLT, ALU_SLE, ALU_SCO
	} alu_op_t;

	localparam logic [4:0] OP_NOP    = 5'b00001;
	localparam logic [4:0] OP_ADDI   = 5'b01000;
	localparam logic [4:0] OP_SUBI   = 5'b01001;
	localparam logic [4:0] OP_XORI   = 5'b01010;
	localparam logic [4:0] OP_ANDNI  = 5'b01011;
	localparam logic [4:0] OP_SLBI   = 5'b10010;
	localparam logic [4:0] OP_ROLI   = 5'b10100;
	localparam logic [4:0] OP_SLLI   = 5'b10101;
	localparam logic [4:0] OP_RORI   = 5'b10110;
	localparam logic [4:0] OP_SRLI   = 5'b10111;
	localparam logic [4:0] OP_LBI    = 5'b11000;
	localparam logic [4:0] OP_BTR    = 5'b11001;
	localparam logic [4:0] OP_RSHIFT = 5'b11010;
	localparam logic [4:0] OP_RALU   = 5'b11011;
	localparam logic [4:0] OP_SEQ    = 5'b11100;
	localparam logic [4:0] OP_SLT    = 5'b11101;
	localparam logic [4:0] OP_SLE    = 5'b11110;
	localparam logic [4:0] OP_SCO    = 5'b11111;

endpackage

// File: source/issue_if.sv
/*
 * Issue bundle from decode to execute, one instruction per cycle
 */
`timescale 1ns/100ps

interface issue_if;

	// Set when the instruction writes a register
	logic              valid;
	cpu_pkg::alu_op_t  op;
	cpu_pkg::reg_sel_t dest;
	cpu_pkg::word_t    op_a;
	cpu_pkg::word_t    op_b;

	modport producer (
		output valid,
		output op,
		output dest,
		output op_a,
		output op_b
	);

	modport consumer (
		input valid,
		input op,
		input dest,
		input op_a,
		input op_b
	);

endinterface

// File: source/decode_stage.sv
/*
 * Decode stage: instruction decode, register read with execute forwarding,
 * and the registered issue bundle towards execute
 */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module decode_stage (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              instr_valid,
	input  cpu_pkg::instr_t   instr,
	output cpu_pkg::reg_sel_t rd_sel_a,
	output cpu_pkg::reg_sel_t rd_sel_b,
	input  cpu_pkg::word_t    rd_data_a,
	input  cpu_pkg::word_t    rd_data_b,
	input  logic              fwd_valid,
	input  cpu_pkg::reg_sel_t fwd_reg,
	input  cpu_pkg::word_t    fwd_data,
	issue_if.producer         iss
);

	logic              writes;
	logic              use_imm;
	cpu_pkg::alu_op_t  op;
	cpu_pkg::reg_sel_t dest;
	cpu_pkg::word_t    imm;
	cpu_pkg::word_t    opnd_a;
	cpu_pkg::word_t    opnd_b;
	cpu_pkg::word_t    imm5_sext;
	cpu_pkg::word_t    imm5_zext;
	cpu_pkg::word_t    imm8_sext;
	cpu_pkg::word_t    imm8_zext;

	// rs sits at the same bits in every view, rt only in the R view
	assign rd_sel_a = instr.r.rs;
	assign rd_sel_b = instr.r.rt;

	assign imm5_sext = {{(`CPU_WIDTH-5){instr.i.imm5[4]}}, instr.i.imm5};
	assign imm5_zext = {{(`CPU_WIDTH-5){1'b0}}, instr.i.imm5};
	assign imm8_sext = {{(`CPU_WIDTH-8){instr.l.imm8[7]}}, instr.l.imm8};
	assign imm8_zext = {{(`CPU_WIDTH-8){1'b0}}, instr.l.imm8};

	always_comb begin
		writes  = 1'b0;
		use_imm = 1'b0;
		op      = cpu_pkg::ALU_PASS_B;
		dest    = instr.r.rd;
		imm     = imm5_zext;
		case (instr.r.opcode)
			cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI: begin
				writes  = 1'b1;
				use_imm = 1'b1;
				op      = (instr.i.opcode == cpu_pkg::OP_ADDI) ? cpu_pkg::ALU_ADD :
					cpu_pkg::ALU_SUB;
				dest    = instr.i.rd;
				imm     = imm5_sext;
			end
			cpu_pkg::OP_XORI, cpu_pkg::OP_ANDNI, cpu_pkg::OP_ROLI, cpu_pkg::OP_SLLI,
			cpu_pkg::OP_RORI, cpu_pkg::OP_SRLI: begin
				writes  = 1'b1;
				use_imm = 1'b1;
				dest    = instr.i.rd;
				// Low opcode bits pick the operation within each group
				case (instr.i.opcode[2:0])
					3'b010:  op = cpu_pkg::ALU_XOR;
					3'b011:  op = cpu_pkg::ALU_ANDN;
					3'b100:  op = cpu_pkg::ALU_ROL;
					3'b101:  op = cpu_pkg::ALU_SLL;
					3'b110:  op = cpu_pkg::ALU_ROR;
					default: op = cpu_pkg::ALU_SRL;
				endcase
			end
			cpu_pkg::OP_LBI, cpu_pkg::OP_SLBI: begin
				writes  = 1'b1;
				use_imm = 1'b1;
				dest    = instr.l.rs;
				op      = (instr.l.opcode == cpu_pkg::OP_LBI) ? cpu_pkg::ALU_PASS_B :
					cpu_pkg::ALU_SLBI;
				imm     = (instr.l.opcode == cpu_pkg::OP_LBI) ? imm8_sext : imm8_zext;
			end
			cpu_pkg::OP_BTR: begin
				writes = 1'b1;
				op     = cpu_pkg::ALU_BTR;
				dest   = instr.i.rd;
			end
			cpu_pkg::OP_RALU: begin
				writes = 1'b1;
				op     = cpu_pkg::alu_op_t'({2'b00, instr.r.funct});
			end
			cpu_pkg::OP_RSHIFT: begin
				writes = 1'b1;
				op     = cpu_pkg::alu_op_t'({2'b01, instr.r.funct});
			end
			cpu_pkg::OP_SEQ: begin
				writes = 1'b1;
				op     = cpu_pkg::ALU_SEQ;
			end
			cpu_pkg::OP_SLT: begin
				writes = 1'b1;
				op     = cpu_pkg::ALU_SLT;
			end
			cpu_pkg::OP_SLE: begin
				writes = 1'b1;
				op     = cpu_pkg::ALU_SLE;
			end
			cpu_pkg::OP_SCO: begin
				writes = 1'b1;
				op     = cpu_pkg::ALU_SCO;
			end
			cpu_pkg::OP_NOP: writes = 1'b0;
			// Anything unknown retires silently
			default: writes = 1'b0;
		endcase
	end

	// Execute result wins over the register file, which already bypasses writeback
	assign opnd_a = (fwd_valid && fwd_reg == rd_sel_a) ? fwd_data : rd_data_a;
	assign opnd_b = (fwd_valid && fwd_reg == rd_sel_b) ? fwd_data : rd_data_b;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			iss.valid <= 1'b0;
		end else begin
			iss.valid <= instr_valid && writes;
		end
	end

	always_ff @(posedge clk) begin
		iss.op   <= op;
		iss.dest <= dest;
		iss.op_a <= opnd_a;
		iss.op_b <= use_imm ? imm : opnd_b;
	end

endmodule

// File: source/reg_file.sv
/*
 * Eight-entry register file, two read ports and one write port,
 * with same-cycle bypass of the write data
 */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module reg_file (
	input  logic              clk,
	input  logic              rst_n,
	input  cpu_pkg::reg_sel_t rd_sel_a,
	input  cpu_pkg::reg_sel_t rd_sel_b,
	output cpu_pkg::word_t    rd_data_a,
	output cpu_pkg::word_t    rd_data_b,
	input  logic              wb_valid,
	input  cpu_pkg::reg_sel_t wb_reg,
	input  cpu_pkg::word_t    wb_data
);

	cpu_pkg::word_t regs [`CPU_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CPU_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid) begin
			regs[wb_reg] <= wb_data;
		end
	end

	// Write in progress is visible to this cycle's reads
	always_comb begin
		if (wb_valid && wb_reg == rd_sel_a) begin
			rd_data_a = wb_data;
		end else begin
			rd_data_a = regs[rd_sel_a];
		end
		if (wb_valid && wb_reg == rd_sel_b) begin
			rd_data_b = wb_data;
		end else begin
			rd_data_b = regs[rd_sel_b];
		end
	end

endmodule

// File: source/execute_stage.sv
/*
 * Execute stage: adder, shifter, set and byte logic feeding the
 * forwarding path and the writeback register
 */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module execute_stage (
	input  logic              clk,
	input  logic              rst_n,
	issue_if.consumer         iss,
	output logic              fwd_valid,
	output cpu_pkg::reg_sel_t fwd_reg,
	output cpu_pkg::word_t    fwd_data,
	output logic              wb_valid,
	output cpu_pkg::reg_sel_t wb_reg,
	output cpu_pkg::word_t    wb_data
);

	logic                     sub_sel;
	cpu_pkg::word_t           add_a;
	cpu_pkg::word_t           add_sum;
	logic                     add_carry;
	logic [`CPU_SHAMT_W-1:0]  shamt;
	logic [2*`CPU_WIDTH-1:0]  rot_l_dbl;
	logic [2*`CPU_WIDTH-1:0]  rot_r_dbl;
	cpu_pkg::word_t           bit_rev;
	logic                     a_eq_b;
	logic                     a_lt_b;
	cpu_pkg::word_t           result;

	// Shared adder, SUB is op_b - op_a
	assign sub_sel = (iss.op == cpu_pkg::ALU_SUB);
	assign add_a   = sub_sel ? ~iss.op_a : iss.op_a;
	assign {add_carry, add_sum} = {1'b0, add_a} + {1'b0, iss.op_b} + {{`CPU_WIDTH{1'b0}}, sub_sel};

	assign shamt = iss.op_b[`CPU_SHAMT_W-1:0];

	// Rotates from a doubled word
	assign rot_l_dbl = {iss.op_a, iss.op_a} << shamt;
	assign rot_r_dbl = {iss.op_a, iss.op_a} >> shamt;

	always_comb begin
		for (int i = 0; i < `CPU_WIDTH; i++) begin
			bit_rev[i] = iss.op_a[`CPU_WIDTH-1-i];
		end
	end

	assign a_eq_b = (iss.op_a == iss.op_b);
	assign a_lt_b = ($signed(iss.op_a) < $signed(iss.op_b));

	always_comb begin
		case (iss.op)
			cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB: result = add_sum;
			cpu_pkg::ALU_XOR:    result = iss.op_a ^ iss.op_b;
			cpu_pkg::ALU_ANDN:   result = iss.op_a & ~iss.op_b;
			cpu_pkg::ALU_ROL:    result = rot_l_dbl[2*`CPU_WIDTH-1:`CPU_WIDTH];
			cpu_pkg::ALU_SLL:    result = iss.op_a << shamt;
			cpu_pkg::ALU_ROR:    result = rot_r_dbl[`CPU_WIDTH-1:0];
			cpu_pkg::ALU_SRL:    result = iss.op_a >> shamt;
			cpu_pkg::ALU_PASS_B: result = iss.op_b;
			// Low byte of rs moves up, immediate fills the bottom
			cpu_pkg::ALU_SLBI:   result = (iss.op_a << 8) | iss.op_b;
			cpu_pkg::ALU_BTR:    result = bit_rev;
			cpu_pkg::ALU_SEQ:    result = {{(`CPU_WIDTH-1){1'b0}}, a_eq_b};
			cpu_pkg::ALU_SLT:    result = {{(`CPU_WIDTH-1){1'b0}}, a_lt_b};
			cpu_pkg::ALU_SLE:    result = {{(`CPU_WIDTH-1){1'b0}}, a_lt_b | a_eq_b};
			cpu_pkg::ALU_SCO:    result = {{(`CPU_WIDTH-1){1'b0}}, add_carry};
			default:             result = '0;
		endcase
	end

	// Result of the instruction now in execute, back to decode
	assign fwd_valid = iss.valid;
	assign fwd_reg   = iss.dest;
	assign fwd_data  = result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= iss.valid;
		end
	end

	always_ff @(posedge clk) begin
		wb_reg  <= iss.dest;
		wb_data <= result;
	end

endmodule

// File: source/cpu_core.sv
/*
 * Processor core top: decode, register file and execute with
 * a fixed two-cycle instruction to writeback latency
 */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_core (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  instr_valid,
	input  logic [`CPU_WIDTH-1:0] instr,
	output logic                  wb_valid,
	output logic [`CPU_SEL_W-1:0] wb_reg,
	output logic [`CPU_WIDTH-1:0] wb_data
);

	cpu_pkg::reg_sel_t rd_sel_a;
	cpu_pkg::reg_sel_t rd_sel_b;
	cpu_pkg::word_t    rd_data_a;
	cpu_pkg::word_t    rd_data_b;
	logic              fwd_valid;
	cpu_pkg::reg_sel_t fwd_reg;
	cpu_pkg::word_t    fwd_data;

	issue_if iss ();

	decode_stage u_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rd_sel_a    (rd_sel_a),
		.rd_sel_b    (rd_sel_b),
		.rd_data_a   (rd_data_a),
		.rd_data_b   (rd_data_b),
		.fwd_valid   (fwd_valid),
		.fwd_reg     (fwd_reg),
		.fwd_data    (fwd_data),
		.iss         (iss.producer)
	);

	reg_file u_reg_file (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_sel_a  (rd_sel_a),
		.rd_sel_b  (rd_sel_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

	execute_stage u_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.iss       (iss.consumer),
		.fwd_valid (fwd_valid),
		.fwd_reg   (fwd_reg),
		.fwd_data  (fwd_data),
		.wb_valid  (wb_valid),
		.wb_reg    (wb_reg),
		.wb_data   (wb_data)
	);

endmodule

// File: dv/cpu_core_asserts.sv
/*
 * Protocol checks on the core's writeback port, bound into cpu_core
 */
`timescale 1ns/100ps

module cpu_core_asserts (
	input logic           clk,
	input logic           rst_n,
	input logic           instr_valid,
	input logic           wb_valid,
	input cpu_pkg::word_t wb_data
);

	// Synchronous reset clears writeback by the next edge
	wb_low_in_reset: assert property (@(posedge clk) !rst_n |=> !wb_valid)
		else $error("wb_valid high while reset is applied");

	// Fixed two-edge latency from instruction to writeback
	wb_follows_instr: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> $past(instr_valid, 2))
		else $error("wb_valid without an instruction two cycles earlier");

	wb_data_known: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid |-> !$isunknown(wb_data))
		else $error("wb_data has unknown bits during writeback");

endmodule

bind cpu_core cpu_core_asserts u_asserts (
	.clk         (clk),
	.rst_n       (rst_n),
	.instr_valid (instr_valid),
	.wb_valid    (wb_valid),
	.wb_data     (wb_data)
);

// File: dv/cpu_core_tb.sv
/*
 * Testbench for cpu_core: directed and random instruction streams checked
 * against an architectural register model in issue order
 */
`timescale 1ns/100ps
`include "cpu_defs.svh"

module cpu_core_tb;

	localparam int N_RANDOM       = 400;
	localparam int DIRECTED_SLOTS = 320;
	// Reset, directed part, random part with at most one idle slot per instruction
	localparam int TEST_SLOTS     = 5 + DIRECTED_SLOTS + 2 * N_RANDOM;

	logic                  clk;
	logic                  rst_n;
	logic                  instr_valid;
	logic [`CPU_WIDTH-1:0] instr;
	logic                  wb_valid;
	logic [`CPU_SEL_W-1:0] wb_reg;
	logic [`CPU_WIDTH-1:0] wb_data;

	cpu_pkg::word_t    model_regs [`CPU_REGS];
	cpu_pkg::reg_sel_t exp_reg_q [$];
	cpu_pkg::word_t    exp_data_q [$];
	logic [31:0]       rnd;

	logic [4:0] set_ops [4] = '{cpu_pkg::OP_SEQ, cpu_pkg::OP_SLT, cpu_pkg::OP_SLE,
		cpu_pkg::OP_SCO};
	logic [4:0] imm_ops [4] = '{cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_XORI,
		cpu_pkg::OP_ANDNI};
	logic [4:0] shift_ops [4] = '{cpu_pkg::OP_ROLI, cpu_pkg::OP_SLLI, cpu_pkg::OP_RORI,
		cpu_pkg::OP_SRLI};
	logic [4:0] imm_vals [4] = '{5'd0, 5'd15, 5'd16, 5'd31};
	logic [4:0] shamt_vals [4] = '{5'd0, 5'd1, 5'd7, 5'd15};

	cpu_core u_cpu_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_random(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic cpu_pkg::word_t enc_r(input logic [4:0] opc, input cpu_pkg::reg_sel_t rs,
			input cpu_pkg::reg_sel_t rt, input cpu_pkg::reg_sel_t rd, input logic [1:0] funct);
		return {opc, rs, rt, rd, funct};
	endfunction

	function automatic cpu_pkg::word_t enc_i(input logic [4:0] opc, input cpu_pkg::reg_sel_t rs,
			input cpu_pkg::reg_sel_t rd, input logic [4:0] imm5);
		return {opc, rs, rd, imm5};
	endfunction

	function automatic cpu_pkg::word_t enc_l(input logic [4:0] opc, input cpu_pkg::reg_sel_t rs,
			input logic [7:0] imm8);
		return {opc, rs, imm8};
	endfunction

	// funct 0..3 is ADD, SUB (b - a), XOR, ANDN
	function automatic cpu_pkg::word_t alu_calc(input logic [1:0] funct,
			input cpu_pkg::word_t a, input cpu_pkg::word_t b);
		case (funct)
			2'd0: return a + b;
			2'd1: return b - a;
			2'd2: return a ^ b;
			default: return a & ~b;
		endcase
	endfunction

	// One bit position per step, kind 0..3 is ROL, SLL, ROR, SRL
	function automatic cpu_pkg::word_t shift_calc(input logic [1:0] kind,
			input cpu_pkg::word_t a, input logic [3:0] n);
		cpu_pkg::word_t res;
		res = a;
		repeat (n) begin
			case (kind)
				2'd0: res = {res[14:0], res[15]};
				2'd1: res = {res[14:0], 1'b0};
				2'd2: res = {res[0], res[15:1]};
				default: res = {1'b0, res[15:1]};
			endcase
		end
		return res;
	endfunction

	// Bits shifted in from the bottom, so bit 0 ends up on top
	function automatic cpu_pkg::word_t reverse_bits(input cpu_pkg::word_t a);
		cpu_pkg::word_t res;
		res = '0;
		for (int i = 0; i < `CPU_WIDTH; i++) begin
			res = {res[14:0], a[i]};
		end
		return res;
	endfunction

	// Returns whether the instruction writes, with its register and value
	function automatic logic ref_exec(input cpu_pkg::word_t ins, output cpu_pkg::reg_sel_t dst,
			output cpu_pkg::word_t val);
		logic [4:0]     opc;
		cpu_pkg::word_t rs;
		cpu_pkg::word_t rt;
		cpu_pkg::word_t simm5;
		cpu_pkg::word_t zimm5;
		logic [16:0]    sum;
		logic           wr;
		opc   = ins[15:11];
		rs    = model_regs[ins[10:8]];
		rt    = model_regs[ins[7:5]];
		simm5 = {{11{ins[4]}}, ins[4:0]};
		zimm5 = {11'b0, ins[4:0]};
		sum   = {1'b0, rs} + {1'b0, rt};
		wr    = 1'b1;
		val   = '0;
		case (opc)
			cpu_pkg::OP_ADDI: val = rs + simm5;
			cpu_pkg::OP_SUBI: val = simm5 - rs;
			cpu_pkg::OP_XORI: val = rs ^ zimm5;
			cpu_pkg::OP_ANDNI: val = rs & ~zimm5;
			cpu_pkg::OP_ROLI, cpu_pkg::OP_SLLI, cpu_pkg::OP_RORI, cpu_pkg::OP_SRLI:
				val = shift_calc(opc[1:0], rs, zimm5[3:0]);
			cpu_pkg::OP_LBI: val = {{8{ins[7]}}, ins[7:0]};
			cpu_pkg::OP_SLBI: val = (rs << 8) | {8'b0, ins[7:0]};
			cpu_pkg::OP_BTR: val = reverse_bits(rs);
			cpu_pkg::OP_RALU: val = alu_calc(ins[1:0], rs, rt);
			cpu_pkg::OP_RSHIFT: val = shift_calc(ins[1:0], rs, rt[3:0]);
			cpu_pkg::OP_SEQ: val = (rs == rt) ? 16'd1 : 16'd0;
			cpu_pkg::OP_SLT: val = ($signed(rs) < $signed(rt)) ? 16'd1 : 16'd0;
			cpu_pkg::OP_SLE: val = ($signed(rs) <= $signed(rt)) ? 16'd1 : 16'd0;
			cpu_pkg::OP_SCO: val = sum[16] ? 16'd1 : 16'd0;
			default: wr = 1'b0;
		endcase
		if (opc inside {cpu_pkg::OP_LBI, cpu_pkg::OP_SLBI}) begin
			dst = ins[10:8];
		end else if (opc inside {cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI, cpu_pkg::OP_XORI,
				cpu_pkg::OP_ANDNI, cpu_pkg::OP_ROLI, cpu_pkg::OP_SLLI, cpu_pkg::OP_RORI,
				cpu_pkg::OP_SRLI, cpu_pkg::OP_BTR}) begin
			dst = ins[7:5];
		end else begin
			dst = ins[4:2];
		end
		return wr;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_reg(input cpu_pkg::reg_sel_t got, input cpu_pkg::reg_sel_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED wb_reg got 0x%h expected 0x%h", got, exp);
			fail_run("writeback register mismatch");
		end
	endtask

	task automatic check_data(input cpu_pkg::word_t got, input cpu_pkg::word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED wb_data got 0x%h expected 0x%h", got, exp);
			fail_run("writeback data mismatch");
		end
	endtask

	task automatic send_instr(input cpu_pkg::word_t ins);
		logic              writes;
		cpu_pkg::reg_sel_t dst;
		cpu_pkg::word_t    val;
		@(negedge clk);
		instr_valid = 1'b1;
		instr       = ins;
		writes      = ref_exec(ins, dst, val);
		if (writes) begin
			exp_reg_q.push_back(dst);
			exp_data_q.push_back(val);
			model_regs[dst] = val;
		end
	endtask

	// Instruction bits change but must be ignored
	task automatic idle_cycle(input cpu_pkg::word_t junk);
		@(negedge clk);
		instr_valid = 1'b0;
		instr       = junk;
	endtask

	always @(posedge clk) begin
		if (rst_n && wb_valid) begin
			if (exp_reg_q.size() == 0) begin
				fail_run("DUT wrote back a result that no instruction should produce");
			end else begin
				check_reg(wb_reg, exp_reg_q.pop_front());
				check_data(wb_data, exp_data_q.pop_front());
			end
		end
	end

	initial begin
		#((TEST_SLOTS + 20) * 100);
		fail_run("Timeout: the run did not finish in the expected time");
	end

	initial begin
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		rnd         = 32'd73327;
		for (int i = 0; i < `CPU_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Every register reads zero out of reset
		for (int r = 0; r < `CPU_REGS; r++) begin
			send_instr(enc_r(cpu_pkg::OP_RALU, 3'(r), 3'(r), 3'(r), 2'd0));
		end
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd1, 8'h80));
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd2, 8'h7F));
		send_instr(enc_i(cpu_pkg::OP_ADDI, 3'd0, 3'd3, 5'h10));
		send_instr(enc_i(cpu_pkg::OP_ADDI, 3'd0, 3'd4, 5'h0F));

		// Corner operands 0x7FFF, 0x8000, 0xFFFF, 0 in r1..r4
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd1, 8'h7F));
		send_instr(enc_l(cpu_pkg::OP_SLBI, 3'd1, 8'hFF));
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd2, 8'h80));
		send_instr(enc_l(cpu_pkg::OP_SLBI, 3'd2, 8'h00));
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd3, 8'hFF));
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd4, 8'h00));
		for (int a = 1; a <= 4; a++) begin
			for (int b = 1; b <= 4; b++) begin
				for (int f = 0; f < 4; f++) begin
					send_instr(enc_r(cpu_pkg::OP_RALU, 3'(a), 3'(b), 3'd5, 2'(f)));
					send_instr(enc_r(set_ops[f], 3'(a), 3'(b), 3'd5, 2'd0));
				end
			end
		end

		// Immediate forms, shift amounts 0 through 15
		for (int o = 0; o < 4; o++) begin
			for (int a = 1; a <= 3; a++) begin
				for (int k = 0; k < 4; k++) begin
					send_instr(enc_i(imm_ops[o], 3'(a), 3'd5, imm_vals[k]));
					send_instr(enc_i(shift_ops[o], 3'(a), 3'd5, shamt_vals[k]));
				end
			end
		end
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd6, 8'h00));
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd7, 8'h0F));
		for (int a = 1; a <= 2; a++) begin
			for (int b = 6; b <= 7; b++) begin
				for (int f = 0; f < 4; f++) begin
					send_instr(enc_r(cpu_pkg::OP_RSHIFT, 3'(a), 3'(b), 3'd5, 2'(f)));
				end
			end
		end

		// Full constants and their bit reversal
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd4, 8'h12));
		send_instr(enc_l(cpu_pkg::OP_SLBI, 3'd4, 8'h34));
		send_instr(enc_i(cpu_pkg::OP_BTR, 3'd4, 3'd5, 5'd0));
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd6, 8'hA5));
		send_instr(enc_l(cpu_pkg::OP_SLBI, 3'd6, 8'hC3));
		send_instr(enc_i(cpu_pkg::OP_BTR, 3'd6, 3'd7, 5'd0));

		// Each add needs the result still in execute
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd1, 8'h03));
		for (int k = 0; k < 8; k++) begin
			send_instr(enc_r(cpu_pkg::OP_RALU, 3'd1, 3'd1, 3'd1, 2'd0));
		end
		// Each add needs the result from two back, now in writeback
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd2, 8'h11));
		send_instr(enc_l(cpu_pkg::OP_LBI, 3'd3, 8'h22));
		for (int k = 0; k < 10; k++) begin
			send_instr(enc_i(cpu_pkg::OP_ADDI, 3'(2 + k % 2), 3'(2 + k % 2), 5'h07));
		end
		send_instr(enc_r(cpu_pkg::OP_RALU, 3'd2, 3'd3, 3'd4, 2'd0));

		// Random mix, unknown opcodes come from the full 5-bit opcode space
		for (int n = 0; n < N_RANDOM; n++) begin
			rnd = next_random(rnd);
			if (rnd[31:30] == 2'b00) begin
				idle_cycle(rnd[15:0]);
			end
			rnd = next_random(rnd);
			if (rnd[29:27] == 3'b000) begin
				send_instr({cpu_pkg::OP_NOP, rnd[10:0]});
			end else begin
				send_instr(rnd[15:0]);
			end
		end
		idle_cycle('0);

		// Two-edge latency, so the last writeback has come and gone by now
		repeat (4) @(posedge clk);
		@(negedge clk);
		if (exp_reg_q.size() != 0) begin
			fail_run("Expected writebacks were still outstanding at the end");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

// File: compile.f
+incdir+source
source/cpu_pkg.sv
source/issue_if.sv
source/decode_stage.sv
source/reg_file.sv
source/execute_stage.sv
source/cpu_core.sv
dv/cpu_core_asserts.sv
dv/cpu_core_tb.sv

// File: Makefile
# Verilator flow for the processor core testbench

TOP := cpu_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Verification failed" sim.log; then exit 1; fi
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log
